//--- Makefile
VERILATOR ?= verilator
TOP       ?= burst_cmd_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Verification failed" $(LOG); then \
		echo "sim: failure reported in $(LOG)"; exit 1; \
	fi
	@if ! grep -q "Verification passed" $(LOG); then \
		echo "sim: run ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- filelist.f
rtl/burst_pkg.sv
rtl/cmd_input_reg.sv
rtl/burst_len_limit.sv
rtl/burst_align_split.sv
rtl/cmd_credit_issue.sv
rtl/burst_cmd_top.sv
testbench/burst_cmd_assertions.sv
testbench/burst_cmd_tb.sv

//--- rtl/burst_align_split.sv
`timescale 1ns/1ns

module burst_align_split
    import burst_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,

    input  logic [ADDR_WIDTH-1:0] s_addr,
    input  logic [LEN_WIDTH-1:0]  s_len,
    input  logic [ID_WIDTH-1:0]   s_id,
    input  logic                  s_first,
    input  logic                  s_last,
    input  logic                  s_valid,
    output logic                  s_ready,

    output logic [ADDR_WIDTH-1:0] m_addr,
    output logic [LEN_WIDTH-1:0]  m_len,
    output logic [ID_WIDTH-1:0]   m_id,
    output logic                  m_first,
    output logic                  m_last,
    output logic                  m_valid,
    input  logic                  m_ready
);

    align_state_t          state;
    logic [LEN_WIDTH-1:0]  len_base;
    logic                  last_keep;

    logic                  advance;
    logic [UNIT_ALIGN:0]   unit_addr;
    logic [UNIT_ALIGN:0]   end_unit;
    logic                  crossing;
    logic [LEN_WIDTH-1:0]  low_len;

    // ------------------------------
    // boundary check
    // ------------------------------

    // beat index in the page, one spare bit catches the carry
    assign unit_addr = {1'b0, s_addr[ALIGN-1:UNIT_SIZE]};
    assign end_unit  = unit_addr + (UNIT_ALIGN + 1)'(s_len);
    assign crossing  = end_unit[UNIT_ALIGN];

    // beats up to the boundary, minus one
    assign low_len = LEN_WIDTH'((UNIT_ALIGN + 1)'(1 << UNIT_ALIGN) - unit_addr - 1'b1);

    assign advance = !m_valid || m_ready;
    assign s_ready = advance && (state == ALIGN_PASS);

    // ------------------------------
    // output register
    // ------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= ALIGN_PASS;
            m_valid <= 1'b0;
        end
        else if (advance) begin
            if (state == ALIGN_PASS) begin
                m_valid <= s_valid;
                if (s_valid && crossing) begin
                    state <= ALIGN_SECOND;
                end
            end
            else begin
                m_valid <= 1'b1;
                state   <= ALIGN_PASS;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            if (state == ALIGN_PASS) begin
                m_addr    <= s_addr;
                m_len     <= crossing ? low_len : s_len;
                m_id      <= s_id;
                m_first   <= s_first;
                m_last    <= s_last && !crossing;
                len_base  <= s_len;
                last_keep <= s_last;
            end
            else begin
                // upper half starts right after the lower half
                m_addr  <= m_addr + ((ADDR_WIDTH'(m_len) + 1'b1) << UNIT_SIZE);
                m_len   <= len_base - m_len - 1'b1;
                m_first <= 1'b0;
                m_last  <= last_keep;
            end
        end
    end

endmodule

//--- rtl/burst_cmd_top.sv
`timescale 1ns/1ns

module burst_cmd_top
    import burst_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,

    input  logic [ADDR_WIDTH-1:0] s_cmd_addr,
    input  logic [LEN_WIDTH-1:0]  s_cmd_len,
    input  logic [ID_WIDTH-1:0]   s_cmd_id,
    input  logic                  s_cmd_valid,
    output logic                  s_cmd_ready,

    output logic [ADDR_WIDTH-1:0] m_cmd_addr,
    output logic [LEN_WIDTH-1:0]  m_cmd_len,
    output logic [ID_WIDTH-1:0]   m_cmd_id,
    output logic                  m_cmd_first,
    output logic                  m_cmd_last,
    output logic                  m_cmd_valid,
    input  logic                  credit_return
);

    // input register to limiter
    logic [ADDR_WIDTH-1:0] in_addr;
    logic [LEN_WIDTH-1:0]  in_len;
    logic [ID_WIDTH-1:0]   in_id;
    logic                  in_valid;
    logic                  in_ready;

    // limiter to splitter
    logic [ADDR_WIDTH-1:0] lim_addr;
    logic [LEN_WIDTH-1:0]  lim_len;
    logic [ID_WIDTH-1:0]   lim_id;
    logic                  lim_first;
    logic                  lim_last;
    logic                  lim_valid;
    logic                  lim_ready;

    // splitter to issue stage
    logic [ADDR_WIDTH-1:0] spl_addr;
    logic [LEN_WIDTH-1:0]  spl_len;
    logic [ID_WIDTH-1:0]   spl_id;
    logic                  spl_first;
    logic                  spl_last;
    logic                  spl_valid;
    logic                  spl_ready;

    cmd_input_reg u_input_reg (
        .clk     (clk),
        .reset   (reset),
        .s_addr  (s_cmd_addr),
        .s_len   (s_cmd_len),
        .s_id    (s_cmd_id),
        .s_valid (s_cmd_valid),
        .s_ready (s_cmd_ready),
        .m_addr  (in_addr),
        .m_len   (in_len),
        .m_id    (in_id),
        .m_valid (in_valid),
        .m_ready (in_ready)
    );

    burst_len_limit u_len_limit (
        .clk     (clk),
        .reset   (reset),
        .s_addr  (in_addr),
        .s_len   (in_len),
        .s_id    (in_id),
        .s_valid (in_valid),
        .s_ready (in_ready),
        .m_addr  (lim_addr),
        .m_len   (lim_len),
        .m_id    (lim_id),
        .m_first (lim_first),
        .m_last  (lim_last),
        .m_valid (lim_valid),
        .m_ready (lim_ready)
    );

    burst_align_split u_align_split (
        .clk     (clk),
        .reset   (reset),
        .s_addr  (lim_addr),
        .s_len   (lim_len),
        .s_id    (lim_id),
        .s_first (lim_first),
        .s_last  (lim_last),
        .s_valid (lim_valid),
        .s_ready (lim_ready),
        .m_addr  (spl_addr),
        .m_len   (spl_len),
        .m_id    (spl_id),
        .m_first (spl_first),
        .m_last  (spl_last),
        .m_valid (spl_valid),
        .m_ready (spl_ready)
    );

    cmd_credit_issue u_credit_issue (
        .clk           (clk),
        .reset         (reset),
        .s_addr        (spl_addr),
        .s_len         (spl_len),
        .s_id          (spl_id),
        .s_first       (spl_first),
        .s_last        (spl_last),
        .s_valid       (spl_valid),
        .s_ready       (spl_ready),
        .m_addr        (m_cmd_addr),
        .m_len         (m_cmd_len),
        .m_id          (m_cmd_id),
        .m_first       (m_cmd_first),
        .m_last        (m_cmd_last),
        .m_valid       (m_cmd_valid),
        .credit_return (credit_return)
    );

endmodule

//--- rtl/burst_len_limit.sv
`timescale 1ns/1ns

module burst_len_limit
    import burst_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,

    input  logic [ADDR_WIDTH-1:0] s_addr,
    input  logic [LEN_WIDTH-1:0]  s_len,
    input  logic [ID_WIDTH-1:0]   s_id,
    input  logic                  s_valid,
    output logic                  s_ready,

    output logic [ADDR_WIDTH-1:0] m_addr,
    output logic [LEN_WIDTH-1:0]  m_len,
    output logic [ID_WIDTH-1:0]   m_id,
    output logic                  m_first,
    output logic                  m_last,
    output logic                  m_valid,
    input  logic                  m_ready
);

    limit_state_t          state;
    logic [ADDR_WIDTH-1:0] next_addr;
    logic [LEN_WIDTH-1:0]  rem_len;

    logic                  advance;
    logic                  load;
    logic [ADDR_WIDTH-1:0] cur_addr;
    logic [LEN_WIDTH-1:0]  cur_len;
    logic                  is_tail;

    assign advance = !m_valid || m_ready;
    assign s_ready = (state == LIMIT_IDLE) && advance;
    assign load    = advance && ((state == LIMIT_CUT) || s_valid);

    // piece source, new command or the leftover of the current one
    assign cur_addr = (state == LIMIT_IDLE) ? s_addr : next_addr;
    assign cur_len  = (state == LIMIT_IDLE) ? s_len : rem_len;
    assign is_tail  = cur_len < LEN_WIDTH'(MAX_BURST_BEATS);

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= LIMIT_IDLE;
            m_valid <= 1'b0;
        end
        else if (advance) begin
            m_valid <= (state == LIMIT_CUT) || s_valid;
            if (load) begin
                state <= is_tail ? LIMIT_IDLE : LIMIT_CUT;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            m_addr    <= cur_addr;
            m_len     <= is_tail ? cur_len : LEN_WIDTH'(MAX_BURST_BEATS - 1);
            m_first   <= (state == LIMIT_IDLE);
            m_last    <= is_tail;
            next_addr <= cur_addr + ADDR_WIDTH'(BURST_BYTES);
            rem_len   <= cur_len - LEN_WIDTH'(MAX_BURST_BEATS);
            // id is kept for every piece of the command
            if (state == LIMIT_IDLE) begin
                m_id <= s_id;
            end
        end
    end

endmodule

//--- rtl/burst_pkg.sv
package burst_pkg;

    // ------------------------------
    // command geometry
    // ------------------------------

    localparam int ADDR_WIDTH = 32;
    // length is coded as beats minus one
    localparam int LEN_WIDTH = 8;
    localparam int ID_WIDTH = 4;

    // log2 of bytes per beat
    localparam int UNIT_SIZE = 3;
    // log2 of the page boundary in bytes
    localparam int ALIGN = 12;
    // beat index width inside one page
    localparam int UNIT_ALIGN = ALIGN - UNIT_SIZE;

    localparam int MAX_BURST_BEATS = 16;
    localparam int BURST_BYTES = MAX_BURST_BEATS << UNIT_SIZE;

    // ------------------------------
    // memory port credits
    // ------------------------------

    localparam int CREDIT_MAX = 4;
    localparam int CREDIT_WIDTH = $clog2(CREDIT_MAX + 1);

    typedef enum logic {
        LIMIT_IDLE,
        LIMIT_CUT
    } limit_state_t;

    typedef enum logic {
        ALIGN_PASS,
        ALIGN_SECOND
    } align_state_t;

endpackage

//--- rtl/cmd_credit_issue.sv
`timescale 1ns/1ns

module cmd_credit_issue
    import burst_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,

    input  logic [ADDR_WIDTH-1:0] s_addr,
    input  logic [LEN_WIDTH-1:0]  s_len,
    input  logic [ID_WIDTH-1:0]   s_id,
    input  logic                  s_first,
    input  logic                  s_last,
    input  logic                  s_valid,
    output logic                  s_ready,

    output logic [ADDR_WIDTH-1:0] m_addr,
    output logic [LEN_WIDTH-1:0]  m_len,
    output logic [ID_WIDTH-1:0]   m_id,
    output logic                  m_first,
    output logic                  m_last,
    output logic                  m_valid,
    input  logic                  credit_return
);

    logic [CREDIT_WIDTH-1:0] credit_count;

    // one piece per credit, no ready on the memory side
    assign s_ready = credit_count != '0;
    assign m_valid = s_valid && s_ready;

    assign m_addr  = s_addr;
    assign m_len   = s_len;
    assign m_id    = s_id;
    assign m_first = s_first;
    assign m_last  = s_last;

    always_ff @(posedge clk) begin
        if (reset) begin
            credit_count <= CREDIT_WIDTH'(CREDIT_MAX);
        end
        else if (m_valid && !credit_return) begin
            credit_count <= credit_count - 1'b1;
        end
        // saturate, an extra return is a memory side error
        else if (credit_return && !m_valid && credit_count != CREDIT_WIDTH'(CREDIT_MAX)) begin
            credit_count <= credit_count + 1'b1;
        end
    end

endmodule

//--- rtl/cmd_input_reg.sv
`timescale 1ns/1ns

module cmd_input_reg
    import burst_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,

    input  logic [ADDR_WIDTH-1:0] s_addr,
    input  logic [LEN_WIDTH-1:0]  s_len,
    input  logic [ID_WIDTH-1:0]   s_id,
    input  logic                  s_valid,
    output logic                  s_ready,

    output logic [ADDR_WIDTH-1:0] m_addr,
    output logic [LEN_WIDTH-1:0]  m_len,
    output logic [ID_WIDTH-1:0]   m_id,
    output logic                  m_valid,
    input  logic                  m_ready
);

    // free when empty or drained this cycle
    assign s_ready = !m_valid || m_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            m_valid <= 1'b0;
        end
        else if (s_ready) begin
            m_valid <= s_valid;
        end
    end

    // payload only moves on an accepted command
    always_ff @(posedge clk) begin
        if (s_valid && s_ready) begin
            m_addr <= s_addr;
            m_len  <= s_len;
            m_id   <= s_id;
        end
    end

endmodule

//--- testbench/burst_cmd_assertions.sv
`timescale 1ns/1ns

module burst_cmd_assertions
    import burst_pkg::*;
(
    input logic                  clk,
    input logic                  reset,
    input logic [ADDR_WIDTH-1:0] m_cmd_addr,
    input logic [LEN_WIDTH-1:0]  m_cmd_len,
    input logic                  m_cmd_valid,
    input logic                  credit_return
);

    // pieces on the memory side not yet paid back
    logic [7:0]          in_flight;
    // last beat index inside the page with a carry bit for a crossing
    logic [UNIT_ALIGN:0] end_unit;
    // number of failed assertions
    int                  error_count = 0;

    assign end_unit = {1'b0, m_cmd_addr[ALIGN-1:UNIT_SIZE]} + (UNIT_ALIGN + 1)'(m_cmd_len);

    always_ff @(posedge clk) begin
        if (reset) begin
            in_flight <= '0;
        end
        else begin
            in_flight <= in_flight + 8'(m_cmd_valid) - 8'(credit_return);
        end
    end

    // a return with nothing outstanding would push the count past CREDIT_MAX
    a_credit_limit: assert property (@(posedge clk) disable iff (reset)
        credit_return |-> (in_flight != '0) || m_cmd_valid)
        else begin
            $error("credit returned with no piece outstanding");
            error_count = error_count + 1;
        end

    a_page_cross: assert property (@(posedge clk) disable iff (reset)
        m_cmd_valid |-> !end_unit[UNIT_ALIGN])
        else begin
            $error("piece crosses a 4 KiB boundary");
            error_count = error_count + 1;
        end

    a_burst_len: assert property (@(posedge clk) disable iff (reset)
        m_cmd_valid |-> m_cmd_len < LEN_WIDTH'(MAX_BURST_BEATS))
        else begin
            $error("piece longer than the burst limit");
            error_count = error_count + 1;
        end

    a_idle_after_reset: assert property (@(posedge clk)
        $fell(reset) |-> !m_cmd_valid)
        else begin
            $error("memory port valid in the cycle after reset");
            error_count = error_count + 1;
        end

endmodule

//--- testbench/burst_cmd_tb.sv
`timescale 1ns/1ns

module burst_cmd_tb
    import burst_pkg::*;
();

    localparam int PIECE_W = ADDR_WIDTH + LEN_WIDTH + ID_WIDTH + 2;
    localparam int PAGE_BEATS = 1 << (ALIGN - UNIT_SIZE);
    localparam int NUM_CMDS = 36;
    // 256 beats cut into 16 pieces, plus one page split
    localparam int MAX_PIECES = 17;
    localparam int PIECE_CYCLES = 24;
    localparam int WATCHDOG_NS = NUM_CMDS * MAX_PIECES * PIECE_CYCLES * 8;
    localparam int READY_TIMEOUT = MAX_PIECES * PIECE_CYCLES;

    logic                  clk;
    logic                  reset;
    logic [ADDR_WIDTH-1:0] s_cmd_addr;
    logic [LEN_WIDTH-1:0]  s_cmd_len;
    logic [ID_WIDTH-1:0]   s_cmd_id;
    logic                  s_cmd_valid;
    logic                  s_cmd_ready;
    logic [ADDR_WIDTH-1:0] m_cmd_addr;
    logic [LEN_WIDTH-1:0]  m_cmd_len;
    logic [ID_WIDTH-1:0]   m_cmd_id;
    logic                  m_cmd_first;
    logic                  m_cmd_last;
    logic                  m_cmd_valid;
    logic                  credit_return = 1'b0;

    // pieces packed as {addr, len, id, first, last}
    logic [PIECE_W-1:0] got_q[$];
    logic [PIECE_W-1:0] exp_q[$];

    int     issued_count = 0;
    int     returned_count = 0;
    int     return_gap = 0;
    int     max_gap = 0;
    logic   credit_hold = 1'b0;
    integer cmd_seed = 514;
    integer gap_seed = 514;

    burst_cmd_top UUT (
        .clk           (clk),
        .reset         (reset),
        .s_cmd_addr    (s_cmd_addr),
        .s_cmd_len     (s_cmd_len),
        .s_cmd_id      (s_cmd_id),
        .s_cmd_valid   (s_cmd_valid),
        .s_cmd_ready   (s_cmd_ready),
        .m_cmd_addr    (m_cmd_addr),
        .m_cmd_len     (m_cmd_len),
        .m_cmd_id      (m_cmd_id),
        .m_cmd_first   (m_cmd_first),
        .m_cmd_last    (m_cmd_last),
        .m_cmd_valid   (m_cmd_valid),
        .credit_return (credit_return)
    );

    bind burst_cmd_top burst_cmd_assertions u_assertions (
        .clk           (clk),
        .reset         (reset),
        .m_cmd_addr    (m_cmd_addr),
        .m_cmd_len     (m_cmd_len),
        .m_cmd_valid   (m_cmd_valid),
        .credit_return (credit_return)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
        stop_with_failure();
    end

    // a bound assertion failure ends the run at once
    initial begin
        wait (UUT.u_assertions.error_count != 0);
        $display("a bound assertion on the memory port failed");
        stop_with_failure();
    end

    // ------------------------------
    // memory port side
    // ------------------------------

    // every m_cmd_valid pulse is one piece
    always @(posedge clk) begin
        if (!reset && m_cmd_valid) begin
            got_q.push_back({m_cmd_addr, m_cmd_len, m_cmd_id, m_cmd_first, m_cmd_last});
            issued_count = issued_count + 1;
        end
    end

    // pays back one credit per issued piece, with optional random gaps
    always @(negedge clk) begin
        credit_return = 1'b0;
        if (return_gap > 0) begin
            return_gap = return_gap - 1;
        end
        else if (!credit_hold && issued_count > returned_count) begin
            credit_return = 1'b1;
            returned_count = returned_count + 1;
            return_gap = (max_gap > 0) ? int'({$random(gap_seed)} % (max_gap + 1)) : 0;
        end
    end

    task automatic stop_with_failure();
        $display("Verification failed");
        $fatal(1);
    endtask

    // ------------------------------
    // reference model
    // ------------------------------

    task automatic model_command(input logic [ADDR_WIDTH-1:0] addr,
                                 input logic [LEN_WIDTH-1:0] len,
                                 input logic [ID_WIDTH-1:0] id);
        logic [ADDR_WIDTH-1:0] base;
        int                    remaining;
        int                    beats;
        int                    page_room;
        logic                  first;
        logic                  last;
        base = addr;
        remaining = int'(len) + 1;
        first = 1'b1;
        while (remaining > 0) begin
            beats = (remaining > MAX_BURST_BEATS) ? MAX_BURST_BEATS : remaining;
            last = (remaining == beats);
            // beats left before the next page
            page_room = PAGE_BEATS - int'(base[ALIGN-1:UNIT_SIZE]);
            if (beats > page_room) begin
                exp_q.push_back({base, LEN_WIDTH'(page_room - 1), id, first, 1'b0});
                exp_q.push_back({base + ADDR_WIDTH'(page_room << UNIT_SIZE),
                                 LEN_WIDTH'(beats - page_room - 1), id, 1'b0, last});
            end
            else begin
                exp_q.push_back({base, LEN_WIDTH'(beats - 1), id, first, last});
            end
            base = base + ADDR_WIDTH'(beats << UNIT_SIZE);
            remaining = remaining - beats;
            first = 1'b0;
        end
    endtask

    // ------------------------------
    // drivers and checkers
    // ------------------------------

    task automatic send_cmd(input logic [ADDR_WIDTH-1:0] addr,
                            input logic [LEN_WIDTH-1:0] len,
                            input logic [ID_WIDTH-1:0] id);
        int waited;
        model_command(addr, len, id);
        @(negedge clk);
        s_cmd_addr = addr;
        s_cmd_len = len;
        s_cmd_id = id;
        s_cmd_valid = 1'b1;
        waited = 0;
        // ready holds from the falling edge to the transfer edge
        while (!s_cmd_ready) begin
            @(negedge clk);
            waited = waited + 1;
            if (waited > READY_TIMEOUT) begin
                $display("command id %0h was never accepted, s_cmd_ready stayed low", id);
                stop_with_failure();
            end
        end
        @(negedge clk);
        s_cmd_valid = 1'b0;
    endtask

    task automatic check_field(input string name, input int index,
                               input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED %s piece %0d: got 0x%h expected 0x%h", name, index, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic drain_and_compare(input string test_name);
        int                 waited;
        int                 limit;
        int                 count;
        logic [PIECE_W-1:0] got;
        logic [PIECE_W-1:0] exp;
        limit = exp_q.size() * PIECE_CYCLES + 50;
        waited = 0;
        while (got_q.size() < exp_q.size() || returned_count != issued_count) begin
            @(negedge clk);
            waited = waited + 1;
            if (waited > limit) begin
                $display("%s: timed out with %0d of %0d pieces seen", test_name,
                         got_q.size(), exp_q.size());
                stop_with_failure();
            end
        end
        // room for a stray extra piece to show up
        repeat (8) @(negedge clk);
        count = got_q.size();
        check_field("m_cmd_valid pulses", 0, count, exp_q.size());
        for (int i = 0; i < count; i++) begin
            got = got_q[i];
            exp = exp_q[i];
            check_field("m_cmd_addr", i, got[PIECE_W-1 -: ADDR_WIDTH],
                        exp[PIECE_W-1 -: ADDR_WIDTH]);
            check_field("m_cmd_len", i, got[ID_WIDTH+2 +: LEN_WIDTH],
                        exp[ID_WIDTH+2 +: LEN_WIDTH]);
            check_field("m_cmd_id", i, got[2 +: ID_WIDTH], exp[2 +: ID_WIDTH]);
            check_field("m_cmd_first", i, got[1], exp[1]);
            check_field("m_cmd_last", i, got[0], exp[0]);
        end
        got_q.delete();
        exp_q.delete();
    endtask

    // ------------------------------
    // directed tests
    // ------------------------------

    task automatic test_single_piece();
        send_cmd(32'h0001_0100, 8'd3, 4'h5);
        drain_and_compare("single piece");
    endtask

    task automatic test_length_cut();
        // 40 beats cut into 16 + 16 + 8
        send_cmd(32'h0003_0200, 8'd39, 4'ha);
        drain_and_compare("length cut");
    endtask

    task automatic test_page_split();
        send_cmd(32'h0004_0ff0, 8'd3, 4'h3);
        drain_and_compare("page split");
    endtask

    task automatic test_credit_stall();
        int waited;
        credit_hold = 1'b1;
        send_cmd(32'h0002_0000, 8'd39, 4'h1);
        send_cmd(32'h0002_1000, 8'd39, 4'h2);
        send_cmd(32'h0002_2000, 8'd39, 4'h3);
        waited = 0;
        while (s_cmd_ready) begin
            @(negedge clk);
            waited = waited + 1;
            if (waited > READY_TIMEOUT) begin
                $display("s_cmd_ready never dropped while credits were held back");
                stop_with_failure();
            end
        end
        repeat (8) @(negedge clk);
        check_field("m_cmd_valid pulses without credit return", 0, got_q.size(), CREDIT_MAX);
        credit_hold = 1'b0;
        drain_and_compare("credit stall");
    endtask

    task automatic test_random_commands();
        int                    i;
        logic [ADDR_WIDTH-1:0] addr;
        logic [LEN_WIDTH-1:0]  len;
        logic [ID_WIDTH-1:0]   id;
        max_gap = 3;
        for (i = 0; i < 30; i++) begin
            addr = $random(cmd_seed);
            addr[UNIT_SIZE-1:0] = '0;
            len = LEN_WIDTH'($random(cmd_seed));
            id = ID_WIDTH'($random(cmd_seed));
            send_cmd(addr, len, id);
        end
        drain_and_compare("random commands");
        max_gap = 0;
    endtask

    initial begin
        reset = 1'b1;
        s_cmd_addr = '0;
        s_cmd_len = '0;
        s_cmd_id = '0;
        s_cmd_valid = 1'b0;
        repeat (3) @(negedge clk);
        reset = 1'b0;
        test_single_piece();
        test_length_cut();
        test_page_split();
        test_credit_stall();
        test_random_commands();
        // the bound checker watches the memory port over the whole run
        if (UUT.u_assertions.error_count == 0) begin
            $display("Verification passed");
            $finish;
        end
        else begin
            $display("bound assertions flagged %0d memory port errors",
                     UUT.u_assertions.error_count);
            stop_with_failure();
        end
    end

endmodule
